// File: source/inst_fetch_cfg.svh
// Instruction fetch subsystem configuration: bus widths, memory size and window
`ifndef INST_FETCH_CFG_SVH
`define INST_FETCH_CFG_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define IFU_ADDR_WIDTH 32
`define IFU_DATA_WIDTH 64
`define IFU_INST_WIDTH 32

// ------------------------------
// Instruction memory
// ------------------------------
// 1024 words of 64 bits, 8 KiB
`define IFU_MEM_DEPTH_LOG2 10
`define IFU_MEM_BASE 32'h8000_0000

// First fetch comes from the base of the window
`define IFU_RESET_PC `IFU_MEM_BASE

`endif

// File: source/inst_fetch_pkg.sv
// Instruction fetch package: vector types, AXI-lite channel structs and FSM states
`include "inst_fetch_cfg.svh"

package inst_fetch_pkg;

  // ------------------------------
  // Plain vectors
  // ------------------------------
  typedef logic [`IFU_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`IFU_DATA_WIDTH-1:0] data_t;
  typedef logic [`IFU_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`IFU_INST_WIDTH-1:0] inst_t;
  typedef logic [1:0] resp_t;

  // AXI response codes in use
  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // ------------------------------
  // AXI-lite channel payloads
  // ------------------------------
  typedef struct packed {
    addr_t addr;
  } axil_ar_t;

  typedef struct packed {
    addr_t addr;
  } axil_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } axil_r_t;

  // Item handed to the core
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_t;

  // ------------------------------
  // State machines
  // ------------------------------
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;
  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA, F_HALT} fetch_state_e;

endpackage

// File: source/inst_sram_array.sv
// Instruction SRAM storage: byte-writable words with a registered read port
`timescale 1ns/1ps
`include "inst_fetch_cfg.svh"

module inst_sram_array (
  input  logic                            i_aclk,
  input  logic                            i_rd_en,
  input  logic [`IFU_MEM_DEPTH_LOG2-1:0]  i_rd_index,
  output inst_fetch_pkg::data_t           o_rd_data,
  input  logic                            i_wr_en,
  input  logic [`IFU_MEM_DEPTH_LOG2-1:0]  i_wr_index,
  input  inst_fetch_pkg::data_t           i_wr_data,
  input  inst_fetch_pkg::strb_t           i_wr_strb
);
  import inst_fetch_pkg::*;

  localparam int MEM_DEPTH = 1 << `IFU_MEM_DEPTH_LOG2;
  localparam int NUM_BYTES = `IFU_DATA_WIDTH / 8;

  data_t mem [0:MEM_DEPTH-1];

  // ------------------------------
  // Write port
  // ------------------------------
  // Only strobed bytes change
  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (i_wr_strb[b]) begin
          mem[i_wr_index][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  // Output holds its word until the next read
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_index];
    end
  end

endmodule

// File: source/axil_inst_sram_wrap.sv
// AXI-lite slave wrapper around the instruction SRAM with window decode
`timescale 1ns/1ps
`include "inst_fetch_cfg.svh"

module axil_inst_sram_wrap (
  input  logic                       i_aclk,
  input  logic                       i_rst,

  // Read address channel
  input  logic                       i_arvalid,
  output logic                       o_arready,
  input  inst_fetch_pkg::axil_ar_t   i_ar,

  // Read data channel
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output inst_fetch_pkg::axil_r_t    o_r,

  // Write address channel
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  inst_fetch_pkg::axil_aw_t   i_aw,

  // Write data channel
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  inst_fetch_pkg::axil_w_t    i_w,

  // Write response channel
  output logic                       o_bvalid,
  input  logic                       i_bready,
  output inst_fetch_pkg::resp_t      o_bresp
);
  import inst_fetch_pkg::*;

  localparam int OFFSET_LSB = $clog2(`IFU_DATA_WIDTH / 8);
  localparam addr_t WINDOW_BYTES = addr_t'((`IFU_DATA_WIDTH / 8) << `IFU_MEM_DEPTH_LOG2);

  rd_state_e rd_state_q;
  wr_state_e wr_state_q;

  addr_t ar_offset;
  addr_t aw_offset;
  logic  ar_hit;
  logic  aw_hit;
  logic  ar_fire;
  logic  r_fire;
  logic  wr_fire;
  logic  b_fire;
  logic  rd_hit_q;
  resp_t bresp_q;
  data_t rd_word;

  // ------------------------------
  // Address window decode
  // ------------------------------
  // Below the base wraps to a large offset and misses too
  assign ar_offset = i_ar.addr - addr_t'(`IFU_MEM_BASE);
  assign aw_offset = i_aw.addr - addr_t'(`IFU_MEM_BASE);
  assign ar_hit    = ar_offset < WINDOW_BYTES;
  assign aw_hit    = aw_offset < WINDOW_BYTES;

  // ------------------------------
  // Read channel
  // ------------------------------
  assign o_arready = (rd_state_q == RD_IDLE);
  assign o_rvalid  = (rd_state_q == RD_RESP);
  assign ar_fire   = i_arvalid & o_arready;
  assign r_fire    = o_rvalid & i_rready;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (ar_fire) rd_state_q <= RD_RESP;
        RD_RESP: if (r_fire) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // Hit flag lines up with the array output one cycle later
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_hit_q <= ar_hit;
    end
  end

  assign o_r.data = rd_hit_q ? rd_word : '0;
  assign o_r.resp = rd_hit_q ? RESP_OKAY : RESP_DECERR;

  // ------------------------------
  // Write channels
  // ------------------------------
  // AW and W are taken only as a pair
  assign o_awready = (wr_state_q == WR_IDLE) & i_awvalid & i_wvalid;
  assign o_wready  = o_awready;
  assign wr_fire   = o_awready;
  assign o_bvalid  = (wr_state_q == WR_RESP);
  assign b_fire    = o_bvalid & i_bready;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (wr_fire) wr_state_q <= WR_RESP;
        WR_RESP: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_fire) begin
      bresp_q <= aw_hit ? RESP_OKAY : RESP_DECERR;
    end
  end

  assign o_bresp = bresp_q;

  // ------------------------------
  // Storage
  // ------------------------------
  inst_sram_array inst_sram_array_inst (
    .i_aclk     (i_aclk),
    .i_rd_en    (ar_fire & ar_hit),
    .i_rd_index (ar_offset[OFFSET_LSB +: `IFU_MEM_DEPTH_LOG2]),
    .o_rd_data  (rd_word),
    .i_wr_en    (wr_fire & aw_hit),
    .i_wr_index (aw_offset[OFFSET_LSB +: `IFU_MEM_DEPTH_LOG2]),
    .i_wr_data  (i_w.data),
    .i_wr_strb  (i_w.strb)
  );

endmodule

// File: source/inst_fetch_unit.sv
// Instruction fetch unit: PC keeper and single-beat AXI-lite read master
`timescale 1ns/1ps
`include "inst_fetch_cfg.svh"

module inst_fetch_unit (
  input  logic                       i_aclk,
  input  logic                       i_rst,

  // Core side
  input  logic                       i_fetch_en,
  input  logic                       i_redirect,
  input  inst_fetch_pkg::addr_t      i_redirect_pc,
  output logic                       o_inst_valid,
  output inst_fetch_pkg::fetch_t     o_fetch,
  output logic                       o_fetch_err,

  // Read address channel
  output logic                       o_arvalid,
  input  logic                       i_arready,
  output inst_fetch_pkg::axil_ar_t   o_ar,

  // Read data channel
  input  logic                       i_rvalid,
  output logic                       o_rready,
  input  inst_fetch_pkg::axil_r_t    i_r
);
  import inst_fetch_pkg::*;

  fetch_state_e state_q;
  addr_t        pc_q;
  addr_t        addr_q;
  logic         discard_q;
  logic         inst_valid_q;
  logic         fetch_err_q;
  fetch_t       fetch_q;

  logic  launch;
  logic  ar_fire;
  logic  r_fire;
  logic  stale;
  inst_t inst_half;

  // ------------------------------
  // Bus handshakes
  // ------------------------------
  assign o_arvalid = (state_q == F_ADDR);
  assign o_rready  = (state_q == F_DATA);
  assign o_ar.addr = addr_q;
  assign ar_fire   = o_arvalid & i_arready;
  assign r_fire    = i_rvalid & o_rready;

  // A redirect on the response cycle also makes it stale
  assign launch = (state_q == F_IDLE) & i_fetch_en & ~i_redirect;
  assign stale  = discard_q | i_redirect;

  // Word half picked by PC bit 2
  assign inst_half = addr_q[2] ? i_r.data[`IFU_DATA_WIDTH-1 -: `IFU_INST_WIDTH]
                               : i_r.data[`IFU_INST_WIDTH-1:0];

  // ------------------------------
  // Fetch FSM
  // ------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q      <= F_IDLE;
      pc_q         <= `IFU_RESET_PC;
      discard_q    <= 1'b0;
      inst_valid_q <= 1'b0;
      fetch_err_q  <= 1'b0;
    end else begin
      inst_valid_q <= 1'b0;
      fetch_err_q  <= 1'b0;
      case (state_q)
        F_IDLE: begin
          if (launch) state_q <= F_ADDR;
        end
        F_ADDR: begin
          // Address stays on the bus until accepted
          if (ar_fire) state_q <= F_DATA;
          if (i_redirect) discard_q <= 1'b1;
        end
        F_DATA: begin
          if (r_fire) begin
            state_q   <= F_IDLE;
            discard_q <= 1'b0;
            if (!stale) begin
              if (i_r.resp == RESP_OKAY) begin
                inst_valid_q <= 1'b1;
                pc_q         <= pc_q + addr_t'(4);
              end else begin
                fetch_err_q <= 1'b1;
                state_q     <= F_HALT;
              end
            end
          end else if (i_redirect) begin
            discard_q <= 1'b1;
          end
        end
        F_HALT: begin
          if (i_redirect) state_q <= F_IDLE;
        end
        default: state_q <= F_IDLE;
      endcase
      // Redirect wins over the sequential step
      if (i_redirect) pc_q <= i_redirect_pc;
    end
  end

  // ------------------------------
  // Address and item registers
  // ------------------------------
  always_ff @(posedge i_aclk) begin
    if (launch) begin
      addr_q <= pc_q;
    end
    if (r_fire) begin
      fetch_q.pc   <= addr_q;
      fetch_q.inst <= inst_half;
    end
  end

  assign o_inst_valid = inst_valid_q;
  assign o_fetch_err  = fetch_err_q;
  assign o_fetch      = fetch_q;

endmodule

// File: source/inst_fetch_top.sv
// Instruction fetch subsystem top: fetch unit joined to the AXI-lite SRAM
`timescale 1ns/1ps

module inst_fetch_top (
  input  logic                       i_aclk,
  input  logic                       i_rst,

  // Core side
  input  logic                       i_fetch_en,
  input  logic                       i_redirect,
  input  inst_fetch_pkg::addr_t      i_redirect_pc,
  output logic                       o_inst_valid,
  output inst_fetch_pkg::fetch_t     o_fetch,
  output logic                       o_fetch_err,

  // Program loader write channels
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  inst_fetch_pkg::axil_aw_t   i_aw,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  inst_fetch_pkg::axil_w_t    i_w,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  output inst_fetch_pkg::resp_t      o_bresp
);
  import inst_fetch_pkg::*;

  // Read link between fetch unit and SRAM
  logic     arvalid;
  logic     arready;
  axil_ar_t ar;
  logic     rvalid;
  logic     rready;
  axil_r_t  r;

  inst_fetch_unit inst_fetch_unit_inst (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_fetch_en    (i_fetch_en),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_inst_valid  (o_inst_valid),
    .o_fetch       (o_fetch),
    .o_fetch_err   (o_fetch_err),
    .o_arvalid     (arvalid),
    .i_arready     (arready),
    .o_ar          (ar),
    .i_rvalid      (rvalid),
    .o_rready      (rready),
    .i_r           (r)
  );

  axil_inst_sram_wrap axil_inst_sram_wrap_inst (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_ar      (ar),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_r       (r),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_aw      (i_aw),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_w       (i_w),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp)
  );

endmodule

// File: verification/inst_fetch_tb.sv
// Testbench for the instruction fetch subsystem: table-driven load, fetch and redirect
`timescale 1ns/1ps
`include "inst_fetch_cfg.svh"

module inst_fetch_tb;
  import inst_fetch_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int DRAIN_CYCLES = 10;
  localparam int QUIET_CYCLES = 30;
  localparam int MEM_IDX_W = `IFU_MEM_DEPTH_LOG2 + 3;
  localparam int MEM_BYTES = 1 << MEM_IDX_W;
  localparam addr_t BASE = `IFU_MEM_BASE;

  typedef logic [MEM_IDX_W-1:0] byte_idx_t;
  typedef enum {OP_WRITE, OP_RUN, OP_REDIRECT, OP_IDLE} op_e;
  typedef struct {
    op_e   op;
    addr_t addr;
    data_t data;
    strb_t strb;
    int    count;
    resp_t resp;
  } row_t;

  logic     i_aclk;
  logic     i_rst;
  logic     i_fetch_en;
  logic     i_redirect;
  addr_t    i_redirect_pc;
  logic     o_inst_valid;
  fetch_t   o_fetch;
  logic     o_fetch_err;
  logic     i_awvalid;
  logic     o_awready;
  axil_aw_t i_aw;
  logic     i_wvalid;
  logic     o_wready;
  axil_w_t  i_w;
  logic     o_bvalid;
  logic     i_bready;
  resp_t    o_bresp;

  // Reference memory, bytes plus a written flag
  logic [7:0] model_mem [0:MEM_BYTES-1];
  bit         model_known [0:MEM_BYTES-1];

  row_t   rows[$];
  fetch_t items[$];
  int     err_count = 0;
  addr_t  exp_pc = `IFU_RESET_PC;

  inst_fetch_top inst_fetch_top_inst (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_fetch_en    (i_fetch_en),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_inst_valid  (o_inst_valid),
    .o_fetch       (o_fetch),
    .o_fetch_err   (o_fetch_err),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_aw          (i_aw),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .i_w           (i_w),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .o_bresp       (o_bresp)
  );

  initial begin
    i_aclk = 1'b0;
    forever #50 i_aclk = ~i_aclk;
  end

  // Core-side strobes collected mid-cycle
  always @(negedge i_aclk) begin
    if (o_inst_valid === 1'b1) items.push_back(o_fetch);
    if (o_fetch_err === 1'b1) err_count++;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic bit in_window(input addr_t addr);
    return (addr - BASE) < addr_t'(MEM_BYTES);
  endfunction

  function automatic inst_t model_inst(input addr_t pc);
    byte_idx_t idx;
    idx = byte_idx_t'(pc - BASE);
    return {model_mem[idx + byte_idx_t'(3)], model_mem[idx + byte_idx_t'(2)],
            model_mem[idx + byte_idx_t'(1)], model_mem[idx]};
  endfunction

  function automatic bit inst_known(input addr_t pc);
    byte_idx_t idx;
    idx = byte_idx_t'(pc - BASE);
    return in_window(pc) && model_known[idx] && model_known[idx + byte_idx_t'(3)];
  endfunction

  // ------------------------------
  // Checks and failures
  // ------------------------------
  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Mismatch in the fetch subsystem");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT at %0t: %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "Wait limit reached");
  endtask

  // ------------------------------
  // Bus and core-side sequences
  // ------------------------------
  task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
                            input resp_t exp_resp);
    int        waited;
    byte_idx_t idx;
    i_aw.addr = addr;
    i_w.data  = data;
    i_w.strb  = strb;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    waited = 0;
    @(negedge i_aclk);
    while (o_awready !== 1'b1) begin
      if (waited == TIMEOUT_CYCLES) report_timeout("o_awready never rose for a write");
      @(negedge i_aclk);
      waited++;
    end
    check(64'(o_wready), 64'd1, $sformatf("write data ready at %h", addr));
    @(posedge i_aclk);
    #10;
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    waited = 0;
    @(negedge i_aclk);
    while (o_bvalid !== 1'b1) begin
      if (waited == TIMEOUT_CYCLES) report_timeout("o_bvalid never rose after a write");
      @(negedge i_aclk);
      waited++;
    end
    check(64'(o_bresp), 64'(exp_resp), $sformatf("write response at %h", addr));
    @(posedge i_aclk);
    #10;
    if (in_window(addr)) begin
      idx = byte_idx_t'(addr - BASE);
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          model_mem[idx + byte_idx_t'(b)]   = data[b*8 +: 8];
          model_known[idx + byte_idx_t'(b)] = 1'b1;
        end
      end
    end
  endtask

  task automatic take_item(output fetch_t item);
    int waited;
    waited = 0;
    while (items.size() == 0) begin
      if (waited == TIMEOUT_CYCLES) report_timeout("o_inst_valid never pulsed");
      @(posedge i_aclk);
      #10;
      waited++;
    end
    item = items.pop_front();
  endtask

  task automatic check_item(input fetch_t item, input bit check_inst);
    check(64'(item.pc), 64'(exp_pc), "fetch PC");
    if (check_inst) begin
      check(64'(item.inst), 64'(model_inst(item.pc)), $sformatf("instruction at %h", item.pc));
    end
    exp_pc = exp_pc + addr_t'(4);
  endtask

  // Stop new reads and let the last one land
  task automatic drain_items();
    fetch_t item;
    i_fetch_en = 1'b0;
    repeat (DRAIN_CYCLES) @(posedge i_aclk);
    #10;
    while (items.size() > 0) begin
      item = items.pop_front();
      check_item(item, inst_known(item.pc));
    end
  endtask

  task automatic run_fetch(input int count);
    fetch_t item;
    i_fetch_en = 1'b1;
    for (int i = 0; i < count; i++) begin
      take_item(item);
      check_item(item, 1'b1);
    end
    drain_items();
  endtask

  task automatic redirect_fetch(input addr_t target, input int count, input resp_t resp);
    int     waited;
    int     err_before;
    fetch_t item;
    check(64'(items.size()), 64'd0, "instructions before a redirect");
    err_before = err_count;
    i_fetch_en = 1'b1;
    @(posedge i_aclk);
    #10;
    // Old PC read is on the bus now
    i_redirect    = 1'b1;
    i_redirect_pc = target;
    @(posedge i_aclk);
    #10;
    i_redirect = 1'b0;
    exp_pc = target;
    if (resp == RESP_OKAY) begin
      for (int i = 0; i < count; i++) begin
        take_item(item);
        check_item(item, 1'b1);
      end
      drain_items();
    end else begin
      waited = 0;
      while (err_count == err_before) begin
        if (waited == TIMEOUT_CYCLES) report_timeout("o_fetch_err never pulsed");
        @(posedge i_aclk);
        #10;
        waited++;
      end
      repeat (QUIET_CYCLES) @(posedge i_aclk);
      #10;
      check(64'(items.size()), 64'd0, "instructions after a fetch error");
      check(64'(err_count - err_before), 64'd1, "fetch error pulses");
      i_fetch_en = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int count);
    int items_before;
    int err_before;
    items_before = items.size();
    err_before = err_count;
    i_fetch_en = 1'b0;
    repeat (count) @(posedge i_aclk);
    #10;
    check(64'(items.size()), 64'(items_before), "instructions while idle");
    check(64'(err_count), 64'(err_before), "fetch errors while idle");
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic add_row(input op_e op, input addr_t addr, input data_t data,
                         input strb_t strb, input int count, input resp_t resp);
    row_t r;
    r.op    = op;
    r.addr  = addr;
    r.data  = data;
    r.strb  = strb;
    r.count = count;
    r.resp  = resp;
    rows.push_back(r);
  endtask

  task automatic build_table();
    data_t word;
    add_row(OP_IDLE, '0, '0, '0, 20, RESP_OKAY);
    // Program of 64 instructions
    for (int i = 0; i < 32; i++) begin
      word = {$urandom(), $urandom()};
      add_row(OP_WRITE, BASE + addr_t'(8 * i), word, 8'hFF, 0, RESP_OKAY);
    end
    add_row(OP_WRITE, BASE - addr_t'(8), {$urandom(), $urandom()}, 8'hFF, 0, RESP_DECERR);
    add_row(OP_RUN, '0, '0, '0, 64, RESP_OKAY);
    add_row(OP_WRITE, BASE + addr_t'(32'h20), {$urandom(), $urandom()}, 8'h0F, 0, RESP_OKAY);
    add_row(OP_WRITE, BASE + addr_t'(32'h28), {$urandom(), $urandom()}, 8'hF0, 0, RESP_OKAY);
    add_row(OP_REDIRECT, BASE + addr_t'(32'h20), '0, '0, 4, RESP_OKAY);
    add_row(OP_REDIRECT, BASE + addr_t'(32'h40), '0, '0, 8, RESP_OKAY);
    // One byte past the last word
    add_row(OP_REDIRECT, BASE + addr_t'(MEM_BYTES), '0, '0, 0, RESP_DECERR);
    add_row(OP_REDIRECT, BASE + addr_t'(32'h80), '0, '0, 16, RESP_OKAY);
    add_row(OP_IDLE, '0, '0, '0, 10, RESP_OKAY);
  endtask

  task automatic apply_row(input row_t r);
    case (r.op)
      OP_WRITE:    write_word(r.addr, r.data, r.strb, r.resp);
      OP_RUN:      run_fetch(r.count);
      OP_REDIRECT: redirect_fetch(r.addr, r.count, r.resp);
      default:     idle_cycles(r.count);
    endcase
  endtask

  initial begin
    void'($urandom(32'h0e00_8eb1));
    i_rst         = 1'b1;
    i_fetch_en    = 1'b0;
    i_redirect    = 1'b0;
    i_redirect_pc = '0;
    i_awvalid     = 1'b0;
    i_aw          = '0;
    i_wvalid      = 1'b0;
    i_w           = '0;
    i_bready      = 1'b1;
    build_table();
    repeat (10) @(posedge i_aclk);
    #10;
    i_rst = 1'b0;
    check(64'(items.size()), 64'd0, "instructions during reset");
    check(64'(err_count), 64'd0, "fetch errors during reset");
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: inst_fetch.f
+incdir+source
source/inst_fetch_pkg.sv
source/inst_sram_array.sv
source/axil_inst_sram_wrap.sv
source/inst_fetch_unit.sv
source/inst_fetch_top.sv
verification/inst_fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the instruction fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=inst_fetch_sim

verilator --binary --timing -j 0 \
  -f inst_fetch.f \
  --top-module inst_fetch_tb \
  -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
fi

if grep -qxF '** PASS **' "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
